/* aes_defs.svh */
// AES decryption engine sizes shared by the RTL and the testbench
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// AES-128 has ten rounds after the initial key addition
`define AES_NUM_ROUNDS 10

// One round key of four words per round, plus the initial key
`define AES_KEY_WORDS 44

// Width of the APB byte address
`define AES_APB_ADDR_W 12

`endif

/* aes_pkg.sv */
// Cipher data types for the AES decryption datapath
package aes_pkg;

  typedef logic [7:0] byte_t;

  // One column of the state, row 0 in the top byte
  typedef logic [31:0] word_t;

  // Full block with word 0 as the most significant word
  typedef logic [127:0] block_t;

  // The state seen as four columns or as sixteen bytes
  // Byte 4*c+r holds row r of column c, as in FIPS-197
  typedef union packed {
    word_t [0:3]  w;
    byte_t [0:15] b;
  } state_u;

  typedef logic [3:0] round_t;

endpackage

/* aes_regs_pkg.sv */
// APB register map of the AES decryption engine
`include "aes_defs.svh"

package aes_regs_pkg;

  typedef enum logic [`AES_APB_ADDR_W-1:0] {
    CTRL     = 12'h000,
    STATUS   = 12'h004,
    BLOCK0   = 12'h010,
    BLOCK1   = 12'h014,
    BLOCK2   = 12'h018,
    BLOCK3   = 12'h01c,
    RESULT0  = 12'h020,
    RESULT1  = 12'h024,
    RESULT2  = 12'h028,
    RESULT3  = 12'h02c,
    KEY_BASE = 12'h100
  } reg_addr_e;

  localparam int CTRL_START_BIT   = 0;
  localparam int STATUS_READY_BIT = 0;

endpackage

/* aes_inv_sbox.sv */
// Inverse AES S-box applied to all four bytes of a word in parallel
`timescale 1ns/10ps

module aes_inv_sbox (
  input  aes_pkg::word_t sboxw,
  output aes_pkg::word_t new_sboxw
);

  // Inverse substitution table of FIPS-197, one byte in and one byte out
  function automatic aes_pkg::byte_t inv_sub(input aes_pkg::byte_t a);
    case (a)
      8'h00: inv_sub = 8'h52;
      8'h01: inv_sub = 8'h09;
      8'h02: inv_sub = 8'h6a;
      8'h03: inv_sub = 8'hd5;
      8'h04: inv_sub = 8'h30;
      8'h05: inv_sub = 8'h36;
      8'h06: inv_sub = 8'ha5;
      8'h07: inv_sub = 8'h38;
      8'h08: inv_sub = 8'hbf;
      8'h09: inv_sub = 8'h40;
      8'h0a: inv_sub = 8'ha3;
      8'h0b: inv_sub = 8'h9e;
      8'h0c: inv_sub = 8'h81;
      8'h0d: inv_sub = 8'hf3;
      8'h0e: inv_sub = 8'hd7;
      8'h0f: inv_sub = 8'hfb;
      8'h10: inv_sub = 8'h7c;
      8'h11: inv_sub = 8'he3;
      8'h12: inv_sub = 8'h39;
      8'h13: inv_sub = 8'h82;
      8'h14: inv_sub = 8'h9b;
      8'h15: inv_sub = 8'h2f;
      8'h16: inv_sub = 8'hff;
      8'h17: inv_sub = 8'h87;
      8'h18: inv_sub = 8'h34;
      8'h19: inv_sub = 8'h8e;
      8'h1a: inv_sub = 8'h43;
      8'h1b: inv_sub = 8'h44;
      8'h1c: inv_sub = 8'hc4;
      8'h1d: inv_sub = 8'hde;
      8'h1e: inv_sub = 8'he9;
      8'h1f: inv_sub = 8'hcb;
      8'h20: inv_sub = 8'h54;
      8'h21: inv_sub = 8'h7b;
      8'h22: inv_sub = 8'h94;
      8'h23: inv_sub = 8'h32;
      8'h24: inv_sub = 8'ha6;
      8'h25: inv_sub = 8'hc2;
      8'h26: inv_sub = 8'h23;
      8'h27: inv_sub = 8'h3d;
      8'h28: inv_sub = 8'hee;
      8'h29: inv_sub = 8'h4c;
      8'h2a: inv_sub = 8'h95;
      8'h2b: inv_sub = 8'h0b;
      8'h2c: inv_sub = 8'h42;
      8'h2d: inv_sub = 8'hfa;
      8'h2e: inv_sub = 8'hc3;
      8'h2f: inv_sub = 8'h4e;
      8'h30: inv_sub = 8'h08;
      8'h31: inv_sub = 8'h2e;
      8'h32: inv_sub = 8'ha1;
      8'h33: inv_sub = 8'h66;
      8'h34: inv_sub = 8'h28;
      8'h35: inv_sub = 8'hd9;
      8'h36: inv_sub = 8'h24;
      8'h37: inv_sub = 8'hb2;
      8'h38: inv_sub = 8'h76;
      8'h39: inv_sub = 8'h5b;
      8'h3a: inv_sub = 8'ha2;
      8'h3b: inv_sub = 8'h49;
      8'h3c: inv_sub = 8'h6d;
      8'h3d: inv_sub = 8'h8b;
      8'h3e: inv_sub = 8'hd1;
      8'h3f: inv_sub = 8'h25;
      8'h40: inv_sub = 8'h72;
      8'h41: inv_sub = 8'hf8;
      8'h42: inv_sub = 8'hf6;
      8'h43: inv_sub = 8'h64;
      8'h44: inv_sub = 8'h86;
      8'h45: inv_sub = 8'h68;
      8'h46: inv_sub = 8'h98;
      8'h47: inv_sub = 8'h16;
      8'h48: inv_sub = 8'hd4;
      8'h49: inv_sub = 8'ha4;
      8'h4a: inv_sub = 8'h5c;
      8'h4b: inv_sub = 8'hcc;
      8'h4c: inv_sub = 8'h5d;
      8'h4d: inv_sub = 8'h65;
      8'h4e: inv_sub = 8'hb6;
      8'h4f: inv_sub = 8'h92;
      8'h50: inv_sub = 8'h6c;
      8'h51: inv_sub = 8'h70;
      8'h52: inv_sub = 8'h48;
      8'h53: inv_sub = 8'h50;
      8'h54: inv_sub = 8'hfd;
      8'h55: inv_sub = 8'hed;
      8'h56: inv_sub = 8'hb9;
      8'h57: inv_sub = 8'hda;
      8'h58: inv_sub = 8'h5e;
      8'h59: inv_sub = 8'h15;
      8'h5a: inv_sub = 8'h46;
      8'h5b: inv_sub = 8'h57;
      8'h5c: inv_sub = 8'ha7;
      8'h5d: inv_sub = 8'h8d;
      8'h5e: inv_sub = 8'h9d;
      8'h5f: inv_sub = 8'h84;
      8'h60: inv_sub = 8'h90;
      8'h61: inv_sub = 8'hd8;
      8'h62: inv_sub = 8'hab;
      8'h63: inv_sub = 8'h00;
      8'h64: inv_sub = 8'h8c;
      8'h65: inv_sub = 8'hbc;
      8'h66: inv_sub = 8'hd3;
      8'h67: inv_sub = 8'h0a;
      8'h68: inv_sub = 8'hf7;
      8'h69: inv_sub = 8'he4;
      8'h6a: inv_sub = 8'h58;
      8'h6b: inv_sub = 8'h05;
      8'h6c: inv_sub = 8'hb8;
      8'h6d: inv_sub = 8'hb3;
      8'h6e: inv_sub = 8'h45;
      8'h6f: inv_sub = 8'h06;
      8'h70: inv_sub = 8'hd0;
      8'h71: inv_sub = 8'h2c;
      8'h72: inv_sub = 8'h1e;
      8'h73: inv_sub = 8'h8f;
      8'h74: inv_sub = 8'hca;
      8'h75: inv_sub = 8'h3f;
      8'h76: inv_sub = 8'h0f;
      8'h77: inv_sub = 8'h02;
      8'h78: inv_sub = 8'hc1;
      8'h79: inv_sub = 8'haf;
      8'h7a: inv_sub = 8'hbd;
      8'h7b: inv_sub = 8'h03;
      8'h7c: inv_sub = 8'h01;
      8'h7d: inv_sub = 8'h13;
      8'h7e: inv_sub = 8'h8a;
      8'h7f: inv_sub = 8'h6b;
      8'h80: inv_sub = 8'h3a;
      8'h81: inv_sub = 8'h91;
      8'h82: inv_sub = 8'h11;
      8'h83: inv_sub = 8'h41;
      8'h84: inv_sub = 8'h4f;
      8'h85: inv_sub = 8'h67;
      8'h86: inv_sub = 8'hdc;
      8'h87: inv_sub = 8'hea;
      8'h88: inv_sub = 8'h97;
      8'h89: inv_sub = 8'hf2;
      8'h8a: inv_sub = 8'hcf;
      8'h8b: inv_sub = 8'hce;
      8'h8c: inv_sub = 8'hf0;
      8'h8d: inv_sub = 8'hb4;
      8'h8e: inv_sub = 8'he6;
      8'h8f: inv_sub = 8'h73;
      8'h90: inv_sub = 8'h96;
      8'h91: inv_sub = 8'hac;
      8'h92: inv_sub = 8'h74;
      8'h93: inv_sub = 8'h22;
      8'h94: inv_sub = 8'he7;
      8'h95: inv_sub = 8'had;
      8'h96: inv_sub = 8'h35;
      8'h97: inv_sub = 8'h85;
      8'h98: inv_sub = 8'he2;
      8'h99: inv_sub = 8'hf9;
      8'h9a: inv_sub = 8'h37;
      8'h9b: inv_sub = 8'he8;
      8'h9c: inv_sub = 8'h1c;
      8'h9d: inv_sub = 8'h75;
      8'h9e: inv_sub = 8'hdf;
      8'h9f: inv_sub = 8'h6e;
      8'ha0: inv_sub = 8'h47;
      8'ha1: inv_sub = 8'hf1;
      8'ha2: inv_sub = 8'h1a;
      8'ha3: inv_sub = 8'h71;
      8'ha4: inv_sub = 8'h1d;
      8'ha5: inv_sub = 8'h29;
      8'ha6: inv_sub = 8'hc5;
      8'ha7: inv_sub = 8'h89;
      8'ha8: inv_sub = 8'h6f;
      8'ha9: inv_sub = 8'hb7;
      8'haa: inv_sub = 8'h62;
      8'hab: inv_sub = 8'h0e;
      8'hac: inv_sub = 8'haa;
      8'had: inv_sub = 8'h18;
      8'hae: inv_sub = 8'hbe;
      8'haf: inv_sub = 8'h1b;
      8'hb0: inv_sub = 8'hfc;
      8'hb1: inv_sub = 8'h56;
      8'hb2: inv_sub = 8'h3e;
      8'hb3: inv_sub = 8'h4b;
      8'hb4: inv_sub = 8'hc6;
      8'hb5: inv_sub = 8'hd2;
      8'hb6: inv_sub = 8'h79;
      8'hb7: inv_sub = 8'h20;
      8'hb8: inv_sub = 8'h9a;
      8'hb9: inv_sub = 8'hdb;
      8'hba: inv_sub = 8'hc0;
      8'hbb: inv_sub = 8'hfe;
      8'hbc: inv_sub = 8'h78;
      8'hbd: inv_sub = 8'hcd;
      8'hbe: inv_sub = 8'h5a;
      8'hbf: inv_sub = 8'hf4;
      8'hc0: inv_sub = 8'h1f;
      8'hc1: inv_sub = 8'hdd;
      8'hc2: inv_sub = 8'ha8;
      8'hc3: inv_sub = 8'h33;
      8'hc4: inv_sub = 8'h88;
      8'hc5: inv_sub = 8'h07;
      8'hc6: inv_sub = 8'hc7;
      8'hc7: inv_sub = 8'h31;
      8'hc8: inv_sub = 8'hb1;
      8'hc9: inv_sub = 8'h12;
      8'hca: inv_sub = 8'h10;
      8'hcb: inv_sub = 8'h59;
      8'hcc: inv_sub = 8'h27;
      8'hcd: inv_sub = 8'h80;
      8'hce: inv_sub = 8'hec;
      8'hcf: inv_sub = 8'h5f;
      8'hd0: inv_sub = 8'h60;
      8'hd1: inv_sub = 8'h51;
      8'hd2: inv_sub = 8'h7f;
      8'hd3: inv_sub = 8'ha9;
      8'hd4: inv_sub = 8'h19;
      8'hd5: inv_sub = 8'hb5;
      8'hd6: inv_sub = 8'h4a;
      8'hd7: inv_sub = 8'h0d;
      8'hd8: inv_sub = 8'h2d;
      8'hd9: inv_sub = 8'he5;
      8'hda: inv_sub = 8'h7a;
      8'hdb: inv_sub = 8'h9f;
      8'hdc: inv_sub = 8'h93;
      8'hdd: inv_sub = 8'hc9;
      8'hde: inv_sub = 8'h9c;
      8'hdf: inv_sub = 8'hef;
      8'he0: inv_sub = 8'ha0;
      8'he1: inv_sub = 8'he0;
      8'he2: inv_sub = 8'h3b;
      8'he3: inv_sub = 8'h4d;
      8'he4: inv_sub = 8'hae;
      8'he5: inv_sub = 8'h2a;
      8'he6: inv_sub = 8'hf5;
      8'he7: inv_sub = 8'hb0;
      8'he8: inv_sub = 8'hc8;
      8'he9: inv_sub = 8'heb;
      8'hea: inv_sub = 8'hbb;
      8'heb: inv_sub = 8'h3c;
      8'hec: inv_sub = 8'h83;
      8'hed: inv_sub = 8'h53;
      8'hee: inv_sub = 8'h99;
      8'hef: inv_sub = 8'h61;
      8'hf0: inv_sub = 8'h17;
      8'hf1: inv_sub = 8'h2b;
      8'hf2: inv_sub = 8'h04;
      8'hf3: inv_sub = 8'h7e;
      8'hf4: inv_sub = 8'hba;
      8'hf5: inv_sub = 8'h77;
      8'hf6: inv_sub = 8'hd6;
      8'hf7: inv_sub = 8'h26;
      8'hf8: inv_sub = 8'he1;
      8'hf9: inv_sub = 8'h69;
      8'hfa: inv_sub = 8'h14;
      8'hfb: inv_sub = 8'h63;
      8'hfc: inv_sub = 8'h55;
      8'hfd: inv_sub = 8'h21;
      8'hfe: inv_sub = 8'h0c;
      8'hff: inv_sub = 8'h7d;
    endcase
  endfunction

  // Four copies of the table, one per row of the column
  assign new_sboxw[31:24] = inv_sub(sboxw[31:24]);
  assign new_sboxw[23:16] = inv_sub(sboxw[23:16]);
  assign new_sboxw[15:8]  = inv_sub(sboxw[15:8]);
  assign new_sboxw[7:0]   = inv_sub(sboxw[7:0]);

endmodule

/* aes_decipher_core.sv */
// Word-serial AES-128 inverse cipher stepping one round key at a time
`timescale 1ns/10ps
`include "aes_defs.svh"

module aes_decipher_core (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,
  input  aes_pkg::block_t block_in,
  input  aes_pkg::block_t round_key,
  output aes_pkg::round_t round_idx,
  output aes_pkg::block_t result,
  output logic            result_valid,
  output logic            ready
);

  // INIT is the single cycle after round 0 that publishes the result
  typedef enum logic [2:0] {IDLE, INIT, SHIFT, SUB, MIX} fsm_e;

  fsm_e            fsm;
  logic [1:0]      col;
  aes_pkg::state_u st;
  aes_pkg::state_u keyed;
  aes_pkg::word_t  sbox_out;

  //--------------------------------------------------------------------------
  // GF(2^8) helpers
  //--------------------------------------------------------------------------
  function automatic aes_pkg::byte_t gmul(input aes_pkg::byte_t a, input logic [3:0] k);
    aes_pkg::byte_t p;
    aes_pkg::byte_t x;
    p = '0;
    x = a;
    for (int i = 0; i < 4; i++) begin
      if (k[i]) begin
        p = p ^ x;
      end
      x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // Row r moves right by r columns
  function automatic aes_pkg::state_u inv_shift_rows(input aes_pkg::state_u s);
    aes_pkg::state_u t;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        t.b[4 * ((c + r) % 4) + r] = s.b[4 * c + r];
      end
    end
    return t;
  endfunction

  // Each output byte takes 0e, 0b, 0d, 09 times rows r, r+1, r+2, r+3
  function automatic aes_pkg::state_u inv_mix_columns(input aes_pkg::state_u s);
    aes_pkg::state_u t;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        t.b[4 * c + r] = gmul(s.b[4 * c + r], 4'he) ^
                         gmul(s.b[4 * c + (r + 1) % 4], 4'hb) ^
                         gmul(s.b[4 * c + (r + 2) % 4], 4'hd) ^
                         gmul(s.b[4 * c + (r + 3) % 4], 4'h9);
      end
    end
    return t;
  endfunction

  //--------------------------------------------------------------------------
  // Datapath
  //--------------------------------------------------------------------------
  aes_inv_sbox inv_sbox_i (
    .sboxw    (st.w[col]),
    .new_sboxw(sbox_out)
  );

  assign keyed        = st ^ round_key;
  assign result       = st;
  assign result_valid = (fsm == INIT);
  assign ready        = (fsm == IDLE) || (fsm == INIT);

  always_ff @(posedge clk) begin
    case (fsm)
      IDLE: begin
        if (start) begin
          st <= block_in ^ round_key;
        end
      end
      SHIFT:   st <= inv_shift_rows(st);
      SUB:     st.w[col] <= sbox_out;
      MIX:     st <= (round_idx == '0) ? keyed : inv_mix_columns(keyed);
      default: st <= st;
    endcase
  end

  //--------------------------------------------------------------------------
  // Round sequencer
  //--------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fsm       <= IDLE;
      col       <= '0;
      round_idx <= aes_pkg::round_t'(`AES_NUM_ROUNDS);
    end else begin
      case (fsm)
        IDLE: begin
          if (start) begin
            round_idx <= round_idx - 1'b1;
            fsm       <= SHIFT;
          end
        end
        SHIFT: fsm <= SUB;
        SUB: begin
          // Column counter wraps back to 0 after the last column
          col <= col + 1'b1;
          if (col == 2'd3) begin
            fsm <= MIX;
          end
        end
        MIX: begin
          if (round_idx == '0) begin
            fsm <= INIT;
          end else begin
            round_idx <= round_idx - 1'b1;
            fsm       <= SHIFT;
          end
        end
        default: begin
          // Rewind so that round key 10 is selected while idle
          round_idx <= aes_pkg::round_t'(`AES_NUM_ROUNDS);
          fsm       <= IDLE;
        end
      endcase
    end
  end

endmodule

/* aes_apb_regs.sv */
// APB register block holding round keys, the input block and the plaintext
`timescale 1ns/10ps
`include "aes_defs.svh"

module aes_apb_regs (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`AES_APB_ADDR_W-1:0] paddr,
  input  aes_pkg::word_t             pwdata,
  output aes_pkg::word_t             prdata,
  output logic                       pslverr,
  input  aes_pkg::round_t            round_idx,
  input  aes_pkg::block_t            result,
  input  logic                       result_valid,
  input  logic                       ready,
  output logic                       start,
  output aes_pkg::block_t            block_in,
  output aes_pkg::block_t            round_key
);

  localparam int unsigned KEY_SPAN = 4 * `AES_KEY_WORDS;

  aes_pkg::word_t             key_mem [`AES_KEY_WORDS];
  aes_pkg::word_t [0:3]       block_q;
  aes_pkg::word_t [0:3]       result_q;
  aes_pkg::word_t [0:3]       result_w;
  logic [`AES_APB_ADDR_W-1:0] key_off;
  logic [5:0]                 key_idx;
  logic [5:0]                 rk_base;
  logic                       access;
  logic                       is_key;
  logic                       mapped;
  logic                       writable;
  logic                       locked;
  logic                       wr_en;

  assign access   = psel && penable;
  assign key_off  = paddr - aes_regs_pkg::KEY_BASE;
  assign is_key   = key_off < KEY_SPAN;
  assign key_idx  = key_off[7:2];
  assign result_w = result;
  assign block_in = block_q;

  // Round key r is words 4r to 4r+3, column 0 on top
  assign rk_base   = {round_idx, 2'b00};
  assign round_key = {key_mem[rk_base], key_mem[rk_base + 6'd1],
                      key_mem[rk_base + 6'd2], key_mem[rk_base + 6'd3]};

  //--------------------------------------------------------------------------
  // Address decode and read mux
  //--------------------------------------------------------------------------
  always_comb begin
    mapped   = 1'b1;
    writable = 1'b1;
    locked   = 1'b0;
    prdata   = '0;
    case (paddr)
      aes_regs_pkg::CTRL: locked = 1'b1;
      aes_regs_pkg::STATUS: begin
        writable = 1'b0;
        prdata[aes_regs_pkg::STATUS_READY_BIT] = ready;
      end
      aes_regs_pkg::BLOCK0, aes_regs_pkg::BLOCK1,
      aes_regs_pkg::BLOCK2, aes_regs_pkg::BLOCK3: locked = 1'b1;
      aes_regs_pkg::RESULT0, aes_regs_pkg::RESULT1,
      aes_regs_pkg::RESULT2, aes_regs_pkg::RESULT3: begin
        writable = 1'b0;
        // Bypass so the plaintext is visible in the cycle ready rises
        prdata = result_valid ? result_w[paddr[3:2]] : result_q[paddr[3:2]];
      end
      default: begin
        // Misaligned addresses never match above and end up here
        mapped = is_key && (paddr[1:0] == 2'b00);
        locked = 1'b1;
      end
    endcase
  end

  assign pslverr = access && (!mapped || (pwrite && (!writable || (locked && !ready))));
  assign wr_en   = access && pwrite && !pslverr;

  //--------------------------------------------------------------------------
  // Register writes
  //--------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start    <= 1'b0;
      block_q  <= '0;
      result_q <= '0;
      for (int i = 0; i < `AES_KEY_WORDS; i++) begin
        key_mem[i] <= '0;
      end
    end else begin
      start <= wr_en && (paddr == aes_regs_pkg::CTRL) &&
               pwdata[aes_regs_pkg::CTRL_START_BIT];
      if (wr_en) begin
        case (paddr)
          aes_regs_pkg::BLOCK0, aes_regs_pkg::BLOCK1,
          aes_regs_pkg::BLOCK2, aes_regs_pkg::BLOCK3: block_q[paddr[3:2]] <= pwdata;
          default: begin
            if (is_key) begin
              key_mem[key_idx] <= pwdata;
            end
          end
        endcase
      end
      if (result_valid) begin
        result_q <= result_w;
      end
    end
  end

endmodule

/* aes_dec_top.sv */
// AES-128 decryption engine with an APB register interface
`timescale 1ns/10ps
`include "aes_defs.svh"

module aes_dec_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`AES_APB_ADDR_W-1:0] paddr,
  input  aes_pkg::word_t             pwdata,
  output aes_pkg::word_t             prdata,
  output logic                       pslverr
);

  logic            start;
  logic            ready;
  logic            result_valid;
  aes_pkg::round_t round_idx;
  aes_pkg::block_t block_in;
  aes_pkg::block_t round_key;
  aes_pkg::block_t result;

  aes_apb_regs regs_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pslverr     (pslverr),
    .round_idx   (round_idx),
    .result      (result),
    .result_valid(result_valid),
    .ready       (ready),
    .start       (start),
    .block_in    (block_in),
    .round_key   (round_key)
  );

  aes_decipher_core core_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .block_in    (block_in),
    .round_key   (round_key),
    .round_idx   (round_idx),
    .result      (result),
    .result_valid(result_valid),
    .ready       (ready)
  );

endmodule

/* aes_dec_properties.sv */
// Protocol checks on the APB port and the start/ready handshake of the decryption engine
`timescale 1ns/10ps
`include "aes_defs.svh"

module aes_dec_properties (
  input logic clk,
  input logic rst_n,
  input logic psel,
  input logic penable,
  input logic pslverr,
  input logic start,
  input logic ready
);

  // Ten rounds of InvShiftRows, four S-box columns and the key/mix step
  localparam int LATENCY = `AES_NUM_ROUNDS * 6;

  logic tracking;
  int   since_start;
  logic pslverr_bad = 1'b0;
  logic start_bad   = 1'b0;
  logic ready_bad   = 1'b0;
  logic failed;

  assign failed = pslverr_bad | start_bad | ready_bad;

  // Counts the edges since the core accepted start
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tracking    <= 1'b0;
      since_start <= 0;
    end else if (start) begin
      tracking    <= 1'b1;
      since_start <= 1;
    end else if (tracking) begin
      if (since_start == LATENCY + 1) begin
        tracking <= 1'b0;
      end
      since_start <= since_start + 1;
    end
  end

  // --------------------------------------------------------------------------
  // APB and handshake rules
  // --------------------------------------------------------------------------
  pslverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr |-> (psel && penable))
  else begin
    $error("pslverr is high outside an APB access cycle");
    pslverr_bad = 1'b1;
  end

  start_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    start |=> !start)
  else begin
    $error("start stayed high for more than one cycle");
    start_bad = 1'b1;
  end

  busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
    (tracking && (since_start <= LATENCY)) |-> !ready)
  else begin
    $error("ready returned before the last round finished");
    ready_bad = 1'b1;
  end

  ready_on_time: assert property (@(posedge clk) disable iff (!rst_n)
    (tracking && (since_start == LATENCY + 1)) |-> ready)
  else begin
    $error("ready did not return right after the last round");
    ready_bad = 1'b1;
  end

endmodule

/* tb_aes_dec.sv */
// Testbench for the APB AES-128 decryption engine using the FIPS-197 C.1 vector
`timescale 1ns/10ps
`include "aes_defs.svh"

module tb_aes_dec;

  typedef logic [`AES_APB_ADDR_W-1:0] addr_t;

  localparam int CLK_PERIOD = 20;
  localparam int LATENCY    = `AES_NUM_ROUNDS * 6;
  // Key load plus every register access outside the status polls
  localparam int NUM_XFERS   = `AES_KEY_WORDS + 30;
  localparam int TEST_CYCLES = 4 + 3 * NUM_XFERS + 3 * (LATENCY + 4);
  localparam int TIMEOUT_NS  = 4 * TEST_CYCLES * CLK_PERIOD;

  localparam aes_pkg::block_t CIPHER = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam aes_pkg::block_t PLAIN  = 128'h00112233445566778899aabbccddeeff;

  // Round keys 0 to 10 of the key 000102..0f, column 0 on top
  localparam aes_pkg::block_t ROUND_KEYS [0:10] = '{
    128'h000102030405060708090a0b0c0d0e0f,
    128'hd6aa74fdd2af72fadaa678f1d6ab76fe,
    128'hb692cf0b643dbdf1be9bc5006830b3fe,
    128'hb6ff744ed2c2c9bf6c590cbf0469bf41,
    128'h47f7f7bc95353e03f96c32bcfd058dfd,
    128'h3caaa3e8a99f9deb50f3af57adf622aa,
    128'h5e390f7df7a69296a7553dc10aa31f6b,
    128'h14f9701ae35fe28c440adf4d4ea9c026,
    128'h47438735a41c65b9e016baf4aebf7ad2,
    128'h549932d1f08557681093ed9cbe2c974e,
    128'h13111d7fe3944a17f307a78b4d2b30c5
  };

  logic           clk;
  logic           rst_n;
  logic           psel;
  logic           penable;
  logic           pwrite;
  addr_t          paddr;
  aes_pkg::word_t pwdata;
  aes_pkg::word_t prdata;
  logic           pslverr;

  aes_dec_top aes_dec_top_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .paddr  (paddr),
    .pwdata (pwdata),
    .prdata (prdata),
    .pslverr(pslverr)
  );

  bind aes_dec_top aes_dec_properties props_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .psel   (psel),
    .penable(penable),
    .pslverr(pslverr),
    .start  (start),
    .ready  (ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic expect_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    assert (act === exp) else begin
      stop_with_failure($sformatf("FAILED %s: expected %08h, actual %08h", name, exp, act));
    end
  endtask

  // One APB transfer, sampled in the middle of the access cycle
  task automatic apb_transfer(input logic wr, input addr_t addr, input aes_pkg::word_t wdata,
                              output aes_pkg::word_t rdata, output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_reg(input string name, input addr_t addr, input aes_pkg::word_t data,
                           input logic exp_err);
    aes_pkg::word_t rdata;
    logic           err;
    apb_transfer(1'b1, addr, data, rdata, err);
    expect_value({name, " pslverr"}, 32'(exp_err), 32'(err));
  endtask

  task automatic read_reg(input string name, input addr_t addr, input aes_pkg::word_t exp_data,
                          input logic exp_err);
    aes_pkg::word_t rdata;
    logic           err;
    apb_transfer(1'b0, addr, '0, rdata, err);
    expect_value({name, " pslverr"}, 32'(exp_err), 32'(err));
    expect_value(name, exp_data, rdata);
  endtask

  task automatic wait_ready();
    aes_pkg::word_t rdata;
    logic           err;
    rdata = '0;
    while (!rdata[aes_regs_pkg::STATUS_READY_BIT]) begin
      apb_transfer(1'b0, aes_regs_pkg::STATUS, '0, rdata, err);
    end
  endtask

  task automatic load_vector();
    for (int k = 0; k < `AES_KEY_WORDS; k++) begin
      write_reg($sformatf("key word %0d", k), addr_t'(aes_regs_pkg::KEY_BASE + 4 * k),
                ROUND_KEYS[k / 4][127 - 32 * (k % 4) -: 32], 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      write_reg($sformatf("block%0d", i), addr_t'(aes_regs_pkg::BLOCK0 + 4 * i),
                CIPHER[127 - 32 * i -: 32], 1'b0);
    end
  endtask

  task automatic check_plaintext(input string label, input aes_pkg::block_t exp);
    for (int i = 0; i < 4; i++) begin
      read_reg($sformatf("%s result%0d", label, i), addr_t'(aes_regs_pkg::RESULT0 + 4 * i),
               exp[127 - 32 * i -: 32], 1'b0);
    end
  endtask

  always @(posedge aes_dec_top_i.props_i.failed) begin
    stop_with_failure("A protocol assertion on the DUT failed");
  end

  initial begin
    #(TIMEOUT_NS);
    stop_with_failure("Simulation hung, the watchdog ran out before the tests ended");
  end

  initial begin
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    read_reg("status after reset", aes_regs_pkg::STATUS,
             32'(1) << aes_regs_pkg::STATUS_READY_BIT, 1'b0);
    check_plaintext("after reset", '0);

    load_vector();
    write_reg("first start", aes_regs_pkg::CTRL, 32'h1, 1'b0);
    wait_ready();
    check_plaintext("first decrypt", PLAIN);

    // Writes while busy must be refused and leave the running block alone
    write_reg("second start", aes_regs_pkg::CTRL, 32'h1, 1'b0);
    write_reg("ctrl while busy", aes_regs_pkg::CTRL, 32'h1, 1'b1);
    write_reg("block1 while busy", aes_regs_pkg::BLOCK1, 32'hffffffff, 1'b1);
    write_reg("key0 while busy", aes_regs_pkg::KEY_BASE, 32'hffffffff, 1'b1);
    wait_ready();
    check_plaintext("refused writes", PLAIN);

    read_reg("unmapped read", addr_t'(12'h080), '0, 1'b1);
    write_reg("unmapped write", addr_t'(12'h080), 32'h12345678, 1'b1);
    write_reg("result0 write", aes_regs_pkg::RESULT0, 32'h12345678, 1'b1);

    write_reg("third start", aes_regs_pkg::CTRL, 32'h1, 1'b0);
    wait_ready();
    check_plaintext("repeat decrypt", PLAIN);

    repeat (2) @(posedge clk);
    if (aes_dec_top_i.props_i.failed) begin
      stop_with_failure("A protocol assertion on the DUT failed");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

/* tb.f */
+incdir+.
aes_pkg.sv
aes_regs_pkg.sv
aes_inv_sbox.sv
aes_decipher_core.sv
aes_apb_regs.sv
aes_dec_top.sv
aes_dec_properties.sv
tb_aes_dec.sv

/* run.sh */
#!/bin/sh
# Build the AES decryption testbench with Verilator, run it and check the log
verilator --binary --assert --top-module tb_aes_dec -f tb.f -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "BUILD FAILED"; exit 1; }
./obj_dir/tb_sim +verilator+error+limit+10 > sim.log 2>&1
cat sim.log
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
